//--- hdl/cam_pkg.sv
// ##########################################################################
// shared types for the rover vision and steering path
// widths, camera word and expanded pixel structs,
// verdict, remote command and motion encodings
// ##########################################################################

`default_nettype none

package cam_pkg;

  // column index width, frames up to 1024 wide
  localparam int COL_W = 10;

  // per-region orange counter width
  // 320x240 frame needs 17 bits in the worst case
  localparam int CNT_W = 17;

  // incoming camera word, one per raw strobe
  typedef struct packed {
    // r in [11:8], g in [7:4], b in [3:0]
    logic [11:0] rgb444;
    // first pixel of a line
    logic        sol;
    // last pixel of a frame
    logic        eof;
  } raw_pix_t;

  // expanded pixel with its column
  typedef struct packed {
    logic [7:0]       r;
    logic [7:0]       g;
    logic [7:0]       b;
    logic [COL_W-1:0] x;
    logic             eof;
  } pixel_t;

  // direction verdict, also used as the region tag
  typedef enum logic [1:0] {
    dir_none,
    dir_left,
    dir_center,
    dir_right
  } dir_e;

  // one verdict per frame
  typedef struct packed {
    logic detected;
    dir_e dir;
  } verdict_t;

  // decoded remote buttons
  typedef enum logic [1:0] {
    cmd_none,
    cmd_start,
    cmd_stop
  } cmd_e;

  // drive commands to the motor side
  typedef enum logic [2:0] {
    mot_stop,
    mot_forward,
    mot_left,
    mot_right,
    mot_spin
  } motion_e;

endpackage

`default_nettype wire

//--- hdl/pixel_unpack.sv
// ##########################################################################
// pixel_unpack
// expands RGB444 camera words to 8-bit channels and
// tags each pixel with its column within the line
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module pixel_unpack #(
  parameter int FRAME_WIDTH = 320
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              raw_valid,
  input  cam_pkg::raw_pix_t raw,
  output logic              pix_valid,
  output cam_pkg::pixel_t   pix
);

  // current column, last value handed out
  logic [cam_pkg::COL_W-1:0] col;
  logic [cam_pkg::COL_W-1:0] col_nxt;

  // sol restarts the line at column 0
  assign col_nxt = raw.sol ? '0 : col + 1'b1;

  // column and strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      col       <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= raw_valid;
      if (raw_valid) begin
        col <= col_nxt;
      end
    end
  end

  // payload, nibble repeated into both halves
  // so 4'hf maps to 8'hff and 4'h0 to 8'h00
  always_ff @(posedge clk) begin
    if (raw_valid) begin
      pix.r   <= {raw.rgb444[11:8], raw.rgb444[11:8]};
      pix.g   <= {raw.rgb444[7:4], raw.rgb444[7:4]};
      pix.b   <= {raw.rgb444[3:0], raw.rgb444[3:0]};
      pix.x   <= col_nxt;
      pix.eof <= raw.eof;
    end
  end

  // camera must start a new line before running off the edge
  a_col_in_frame : assert property (@(posedge clk) disable iff (rst)
    (raw_valid && !raw.sol) |-> (col < FRAME_WIDTH - 1));

endmodule

`default_nettype wire

//--- hdl/orange_detector.sv
// ##########################################################################
// orange_detector
// per-pixel orange threshold test, recolours hits
// to pure red for the preview stream
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module orange_detector #(
  parameter int R_MIN = 180,
  parameter int G_MIN = 60,
  parameter int G_MAX = 160,
  parameter int B_MAX = 80
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            pix_valid,
  input  cam_pkg::pixel_t pix,
  output logic            det_valid,
  output logic            det_orange,
  output cam_pkg::pixel_t det_pix
);

  logic r_ok;
  logic g_ok;
  logic b_ok;
  logic is_orange;
  cam_pkg::pixel_t recoloured;

  // channel window checks
  assign r_ok = (pix.r >= R_MIN);
  assign g_ok = (pix.g >= G_MIN) && (pix.g <= G_MAX);
  assign b_ok = (pix.b <= B_MAX);

  // red must also dominate green, rejects yellows
  assign is_orange = r_ok && g_ok && b_ok && (pix.r > pix.g);

  // hit becomes pure red, column and eof untouched
  always_comb begin
    recoloured = pix;
    if (is_orange) begin
      recoloured.r = 8'hff;
      recoloured.g = 8'h00;
      recoloured.b = 8'h00;
    end
  end

  // strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      det_valid <= 1'b0;
    end else begin
      det_valid <= pix_valid;
    end
  end

  // flag and pixel travel together
  always_ff @(posedge clk) begin
    if (pix_valid) begin
      det_orange <= is_orange;
      det_pix    <= recoloured;
    end
  end

endmodule

`default_nettype wire

//--- hdl/direction_classifier.sv
// ##########################################################################
// direction_classifier
// counts orange pixels per third of the frame and
// issues one direction verdict at end of frame
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module direction_classifier #(
  parameter int FRAME_WIDTH = 320,
  parameter int MIN_COUNT   = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              det_valid,
  input  logic              det_orange,
  input  cam_pkg::pixel_t   det_pix,
  output logic              verdict_valid,
  output cam_pkg::verdict_t verdict
);

  // region boundaries, exclusive upper ends
  localparam int LEFT_END   = FRAME_WIDTH / 3;
  localparam int CENTER_END = (2 * FRAME_WIDTH) / 3;

  logic [cam_pkg::CNT_W-1:0] cnt_left;
  logic [cam_pkg::CNT_W-1:0] cnt_center;
  logic [cam_pkg::CNT_W-1:0] cnt_right;
  logic [cam_pkg::CNT_W-1:0] left_nxt;
  logic [cam_pkg::CNT_W-1:0] center_nxt;
  logic [cam_pkg::CNT_W-1:0] right_nxt;
  logic [cam_pkg::CNT_W+1:0] total;
  logic                      frame_end;
  logic                      detected;
  cam_pkg::dir_e             region;
  cam_pkg::dir_e             best_dir;

  assign frame_end = det_valid && det_pix.eof;

  // which third this column falls in
  always_comb begin
    if (det_pix.x < LEFT_END) begin
      region = cam_pkg::dir_left;
    end else if (det_pix.x < CENTER_END) begin
      region = cam_pkg::dir_center;
    end else begin
      region = cam_pkg::dir_right;
    end
  end

  // counts including the current pixel
  // eof pixel counts toward its own frame
  always_comb begin
    left_nxt   = cnt_left;
    center_nxt = cnt_center;
    right_nxt  = cnt_right;
    if (det_valid && det_orange) begin
      case (region)
        cam_pkg::dir_left:   left_nxt   = cnt_left + 1'b1;
        cam_pkg::dir_center: center_nxt = cnt_center + 1'b1;
        default:             right_nxt  = cnt_right + 1'b1;
      endcase
    end
  end

  assign total    = left_nxt + center_nxt + right_nxt;
  assign detected = (total >= MIN_COUNT);

  // largest region wins
  // centre takes ties, then left over right
  always_comb begin
    if ((center_nxt >= left_nxt) && (center_nxt >= right_nxt)) begin
      best_dir = cam_pkg::dir_center;
    end else if (left_nxt >= right_nxt) begin
      best_dir = cam_pkg::dir_left;
    end else begin
      best_dir = cam_pkg::dir_right;
    end
  end

  // counters clear at frame end, nothing carries over
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_left      <= '0;
      cnt_center    <= '0;
      cnt_right     <= '0;
      verdict_valid <= 1'b0;
    end else begin
      verdict_valid <= frame_end;
      if (frame_end) begin
        cnt_left   <= '0;
        cnt_center <= '0;
        cnt_right  <= '0;
      end else begin
        cnt_left   <= left_nxt;
        cnt_center <= center_nxt;
        cnt_right  <= right_nxt;
      end
    end
  end

  // verdict payload, held until next frame end
  always_ff @(posedge clk) begin
    if (frame_end) begin
      verdict.detected <= detected;
      verdict.dir      <= detected ? best_dir : cam_pkg::dir_none;
    end
  end

  // frames always span more than one pixel
  a_single_verdict : assert property (@(posedge clk) disable iff (rst)
    verdict_valid |=> !verdict_valid);

endmodule

`default_nettype wire

//--- hdl/drive_fsm.sv
// ##########################################################################
// drive_fsm
// rover mode FSM, combines remote commands with frame
// verdicts and registers the motion request
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module drive_fsm (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,
  input  cam_pkg::cmd_e     cmd,
  input  logic              verdict_valid,
  input  cam_pkg::verdict_t verdict,
  output cam_pkg::motion_e  motion,
  output logic              mode_tracking
);

  typedef enum logic [1:0] {
    mode_idle,
    mode_search,
    mode_track
  } mode_e;

  mode_e            mode;
  mode_e            mode_nxt;
  cam_pkg::motion_e motion_nxt;
  logic             stop_req;
  logic             start_req;

  assign stop_req  = cmd_valid && (cmd == cam_pkg::cmd_stop);
  assign start_req = cmd_valid && (cmd == cam_pkg::cmd_start);

  // next mode, stop beats any verdict in the same cycle
  always_comb begin
    mode_nxt = mode;
    if (stop_req) begin
      mode_nxt = mode_idle;
    end else begin
      case (mode)
        // verdicts ignored here
        mode_idle:   if (start_req) mode_nxt = mode_search;
        mode_search: if (verdict_valid && verdict.detected) mode_nxt = mode_track;
        mode_track:  if (verdict_valid && !verdict.detected) mode_nxt = mode_search;
        default:     mode_nxt = mode_idle;
      endcase
    end
  end

  // motion from next mode
  // tracking steers by the newest verdict, else holds last turn
  always_comb begin
    motion_nxt = motion;
    case (mode_nxt)
      mode_search: motion_nxt = cam_pkg::mot_spin;
      mode_track: begin
        if (verdict_valid && verdict.detected) begin
          case (verdict.dir)
            cam_pkg::dir_left:  motion_nxt = cam_pkg::mot_left;
            cam_pkg::dir_right: motion_nxt = cam_pkg::mot_right;
            default:            motion_nxt = cam_pkg::mot_forward;
          endcase
        end
      end
      default: motion_nxt = cam_pkg::mot_stop;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mode   <= mode_idle;
      motion <= cam_pkg::mot_stop;
    end else begin
      mode   <= mode_nxt;
      motion <= motion_nxt;
    end
  end

  assign mode_tracking = (mode == mode_track);

  // mode and motion registers never disagree
  a_mode_motion : assert property (@(posedge clk) disable iff (rst)
    mode_tracking == ((motion != cam_pkg::mot_stop) && (motion != cam_pkg::mot_spin)));

endmodule

`default_nettype wire

//--- hdl/target_tracker_top.sv
// ##########################################################################
// target_tracker_top
// camera pixel chain into orange detection, direction
// verdict and drive FSM, on a single clock
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module target_tracker_top #(
  parameter int FRAME_WIDTH = 320,
  parameter int R_MIN       = 180,
  parameter int G_MIN       = 60,
  parameter int G_MAX       = 160,
  parameter int B_MAX       = 80,
  parameter int MIN_COUNT   = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              raw_valid,
  input  cam_pkg::raw_pix_t raw,
  input  logic              cmd_valid,
  input  cam_pkg::cmd_e     cmd,
  output logic              prev_valid,
  output cam_pkg::pixel_t   prev_pix,
  output logic              verdict_valid,
  output cam_pkg::verdict_t verdict,
  output cam_pkg::motion_e  motion,
  output logic              mode_tracking
);

  // unpacker to detector
  logic            pix_valid;
  cam_pkg::pixel_t pix;
  // detector to classifier, preview taps the same stream
  logic            det_orange;

  pixel_unpack #(
    .FRAME_WIDTH (FRAME_WIDTH)
  ) u_unpack (
    .clk       (clk),
    .rst       (rst),
    .raw_valid (raw_valid),
    .raw       (raw),
    .pix_valid (pix_valid),
    .pix       (pix)
  );

  orange_detector #(
    .R_MIN (R_MIN),
    .G_MIN (G_MIN),
    .G_MAX (G_MAX),
    .B_MAX (B_MAX)
  ) u_detect (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .det_valid  (prev_valid),
    .det_orange (det_orange),
    .det_pix    (prev_pix)
  );

  direction_classifier #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .MIN_COUNT   (MIN_COUNT)
  ) u_classify (
    .clk           (clk),
    .rst           (rst),
    .det_valid     (prev_valid),
    .det_orange    (det_orange),
    .det_pix       (prev_pix),
    .verdict_valid (verdict_valid),
    .verdict       (verdict)
  );

  drive_fsm u_drive (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .verdict_valid (verdict_valid),
    .verdict       (verdict),
    .motion        (motion),
    .mode_tracking (mode_tracking)
  );

endmodule

`default_nettype wire

//--- tests/tb_tracker_ref.svh
// ##########################################################################
// testbench reference model for the tracker chain
// LFSR step, pixel expansion, orange test, region,
// frame verdict, FSM mode and motion
// ##########################################################################

`ifndef TB_TRACKER_REF_SVH
`define TB_TRACKER_REF_SVH

// FSM modes as the model tracks them
localparam int MODE_IDLE   = 0;
localparam int MODE_SEARCH = 1;
localparam int MODE_TRACK  = 2;

// galois LFSR, x^32 + x^22 + x^2 + x + 1, output bit is s[0]
function automatic logic [31:0] lfsr_step(logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

// 4-bit channel scaled to 8 bits, times 17 spans 0..255
function automatic cam_pkg::pixel_t expand_word(cam_pkg::raw_pix_t w,
                                                logic [cam_pkg::COL_W-1:0] x);
  cam_pkg::pixel_t p;
  p.r   = 8'(w.rgb444[11:8] * 17);
  p.g   = 8'(w.rgb444[7:4] * 17);
  p.b   = 8'(w.rgb444[3:0] * 17);
  p.x   = x;
  p.eof = w.eof;
  return p;
endfunction

// orange window, red above green
function automatic logic orange_hit(cam_pkg::pixel_t p);
  return (p.r >= R_MIN) && (p.g >= G_MIN) && (p.g <= G_MAX) &&
         (p.b <= B_MAX) && (p.r > p.g);
endfunction

function automatic cam_pkg::pixel_t recolour(cam_pkg::pixel_t p);
  cam_pkg::pixel_t q;
  q   = p;
  q.r = 8'd255;
  q.g = 8'd0;
  q.b = 8'd0;
  return q;
endfunction

// 0 left, 1 centre, 2 right
function automatic int region_of(int x);
  if (x < FRAME_WIDTH / 3) begin
    return 0;
  end
  if (x < (2 * FRAME_WIDTH) / 3) begin
    return 1;
  end
  return 2;
endfunction

// ties go to centre, then left
function automatic cam_pkg::verdict_t pick_verdict(int n_left, int n_center, int n_right);
  cam_pkg::verdict_t v;
  v.detected = ((n_left + n_center + n_right) >= MIN_COUNT);
  if (!v.detected) begin
    v.dir = cam_pkg::dir_none;
  end else if ((n_center >= n_left) && (n_center >= n_right)) begin
    v.dir = cam_pkg::dir_center;
  end else if (n_left >= n_right) begin
    v.dir = cam_pkg::dir_left;
  end else begin
    v.dir = cam_pkg::dir_right;
  end
  return v;
endfunction

// stop overrides everything, verdicts only count outside idle
function automatic int next_mode(int mode, logic stop, logic start, logic vv, logic det);
  if (stop) begin
    return MODE_IDLE;
  end
  case (mode)
    MODE_IDLE:   return start ? MODE_SEARCH : MODE_IDLE;
    MODE_SEARCH: return (vv && det) ? MODE_TRACK : MODE_SEARCH;
    default:     return (vv && !det) ? MODE_SEARCH : MODE_TRACK;
  endcase
endfunction

// tracking steers by the newest detected verdict, else holds
function automatic cam_pkg::motion_e motion_for(int mode, logic vv, cam_pkg::verdict_t v,
                                                cam_pkg::motion_e prev);
  if (mode == MODE_IDLE) begin
    return cam_pkg::mot_stop;
  end
  if (mode == MODE_SEARCH) begin
    return cam_pkg::mot_spin;
  end
  if (!(vv && v.detected)) begin
    return prev;
  end
  if (v.dir == cam_pkg::dir_left) begin
    return cam_pkg::mot_left;
  end
  if (v.dir == cam_pkg::dir_right) begin
    return cam_pkg::mot_right;
  end
  return cam_pkg::mot_forward;
endfunction

`endif

//--- tests/tb_target_tracker.sv
// ##########################################################################
// testbench for target_tracker_top
// clock, reset, frame stimulus, preview scoreboard,
// verdict and motion compare tasks, timeout, summary
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_target_tracker;

  // small frame keeps the run short
  localparam int FRAME_WIDTH = 24;
  localparam int R_MIN       = 180;
  localparam int G_MIN       = 60;
  localparam int G_MAX       = 160;
  localparam int B_MAX       = 80;
  localparam int MIN_COUNT   = 6;
  localparam int LINES       = 4;
  localparam int THIRD       = FRAME_WIDTH / 3;
  localparam int NUM_FRAMES  = 13;
  // at most two cycles per pixel, plus idle and command cycles per frame
  localparam int STIM_CYCLES = 10 + NUM_FRAMES * (2 * LINES * FRAME_WIDTH + 12);
  localparam int CYCLE_LIMIT = STIM_CYCLES + 200;

  `include "tb_tracker_ref.svh"

  logic              clk = 1'b0;
  logic              rst;
  logic              raw_valid;
  cam_pkg::raw_pix_t raw;
  logic              cmd_valid;
  cam_pkg::cmd_e     cmd;
  logic              prev_valid;
  cam_pkg::pixel_t   prev_pix;
  logic              verdict_valid;
  cam_pkg::verdict_t verdict;
  cam_pkg::motion_e  motion;
  logic              mode_tracking;

  logic [31:0] lfsr;
  int          cycle = 0;
  int          pixel_errs = 0;
  int          verdict_errs = 0;
  int          motion_errs = 0;
  int          other_errs = 0;

  // scoreboard, parallel queues of value, due cycle and frame number
  cam_pkg::pixel_t   pix_q[$];
  int                pix_due[$];
  int                pix_frame[$];
  cam_pkg::verdict_t verdict_q[$];
  int                verdict_due[$];
  int                verdict_frame[$];

  // inputs as seen at the last rising edge
  logic                      cap_rst = 1'b1;
  logic                      cap_cmd_valid = 1'b0;
  cam_pkg::cmd_e             cap_cmd = cam_pkg::cmd_none;
  logic [cam_pkg::COL_W-1:0] cap_col = '0;
  int                        cap_frame = 0;
  int                        region_cnt[3];
  cam_pkg::pixel_t           exp_pix;

  // FSM model
  int                ref_mode = MODE_IDLE;
  cam_pkg::motion_e  ref_motion = cam_pkg::mot_stop;
  logic              last_vv = 1'b0;
  cam_pkg::verdict_t last_v = '0;

  target_tracker_top #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .R_MIN       (R_MIN),
    .G_MIN       (G_MIN),
    .G_MAX       (G_MAX),
    .B_MAX       (B_MAX),
    .MIN_COUNT   (MIN_COUNT)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .raw_valid     (raw_valid),
    .raw           (raw),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .prev_valid    (prev_valid),
    .prev_pix      (prev_pix),
    .verdict_valid (verdict_valid),
    .verdict       (verdict),
    .motion        (motion),
    .mode_tracking (mode_tracking)
  );

  // 20 ns period
  always #10 clk = ~clk;

  task automatic check_pixel(string name, cam_pkg::pixel_t exp, cam_pkg::pixel_t act);
    if (act !== exp) begin
      pixel_errs++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_verdict(string name, cam_pkg::verdict_t exp, cam_pkg::verdict_t act);
    if (act !== exp) begin
      verdict_errs++;
      $display("MISMATCH %s expected %b/%s actual %b/%s", name,
               exp.detected, exp.dir.name(), act.detected, act.dir.name());
    end
  endtask

  task automatic check_motion(string name, cam_pkg::motion_e exp, cam_pkg::motion_e act);
    if (act !== exp) begin
      motion_errs++;
      $display("MISMATCH %s expected %s actual %s (%0d)", name, exp.name(), act.name(), act);
    end
  endtask

  task automatic finish_run();
    int total;
    total = pixel_errs + verdict_errs + motion_errs + other_errs;
    $display("summary: pixel errors %0d, verdict errors %0d, motion errors %0d, other errors %0d",
             pixel_errs, verdict_errs, motion_errs, other_errs);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // one LFSR step per bit taken
  task automatic get_bits(int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // all inputs change on the falling edge
  task automatic drive_cycle(logic rv, cam_pkg::raw_pix_t w, logic cv, cam_pkg::cmd_e c);
    @(negedge clk);
    raw_valid = rv;
    raw       = w;
    cmd_valid = cv;
    cmd       = c;
  endtask

  task automatic idle(int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, cam_pkg::cmd_none);
  endtask

  task automatic send_cmd(cam_pkg::cmd_e c);
    drive_cycle(1'b0, '0, 1'b1, c);
  endtask

  // n_* orange pixels forced into each third, filled line by line
  // clean background has blue at 0x88 or more, never orange
  task automatic send_frame(int n_left, int n_center, int n_right, logic clean);
    int                want[3];
    int                line;
    int                col;
    int                idx;
    logic [31:0]       bits;
    cam_pkg::raw_pix_t w;
    want[0] = n_left;
    want[1] = n_center;
    want[2] = n_right;
    for (line = 0; line < LINES; line++) begin
      for (col = 0; col < FRAME_WIDTH; col++) begin
        // gap before roughly a quarter of the pixels
        get_bits(2, bits);
        if (bits[1:0] == 2'b11) begin
          idle(1);
        end
        get_bits(12, bits);
        w.rgb444 = bits[11:0];
        w.sol    = (col == 0);
        w.eof    = (line == LINES - 1) && (col == FRAME_WIDTH - 1);
        if (clean) begin
          w.rgb444[3] = 1'b1;
        end
        idx = line * THIRD + (col % THIRD);
        if (idx < want[col / THIRD]) begin
          // r 0xcc..0xff, g 0x44..0x77, b 0x00..0x33
          w.rgb444[11:10] = 2'b11;
          w.rgb444[7:6]   = 2'b01;
          w.rgb444[3:2]   = 2'b00;
        end
        drive_cycle(1'b1, w, 1'b0, cam_pkg::cmd_none);
      end
    end
  endtask

  // rising edge, capture inputs and predict the chain
  always @(posedge clk) begin
    cycle         = cycle + 1;
    cap_rst       = rst;
    cap_cmd_valid = cmd_valid;
    cap_cmd       = cmd;
    if (rst) begin
      cap_col   = '0;
      cap_frame = 0;
      region_cnt = '{0, 0, 0};
    end else if (raw_valid) begin
      cap_col = raw.sol ? '0 : cap_col + 1'b1;
      exp_pix = expand_word(raw, cap_col);
      if (orange_hit(exp_pix)) begin
        region_cnt[region_of(cap_col)]++;
        exp_pix = recolour(exp_pix);
      end
      // preview two edges later, verdict three
      pix_q.push_back(exp_pix);
      pix_due.push_back(cycle + 1);
      pix_frame.push_back(cap_frame);
      if (raw.eof) begin
        verdict_q.push_back(pick_verdict(region_cnt[0], region_cnt[1], region_cnt[2]));
        verdict_due.push_back(cycle + 2);
        verdict_frame.push_back(cap_frame);
        region_cnt = '{0, 0, 0};
        cap_frame++;
      end
    end
    if (cycle >= CYCLE_LIMIT) begin
      other_errs++;
      $display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      finish_run();
    end
  end

  // falling edge, outputs are stable here
  always @(negedge clk) begin
    if (cap_rst) begin
      ref_mode   = MODE_IDLE;
      ref_motion = cam_pkg::mot_stop;
      last_vv    = 1'b0;
    end else begin
      // FSM saw the captured command and last cycle's verdict
      ref_motion = motion_for(next_mode(ref_mode, cap_cmd_valid && (cap_cmd == cam_pkg::cmd_stop),
                                        cap_cmd_valid && (cap_cmd == cam_pkg::cmd_start),
                                        last_vv, last_v.detected),
                              last_vv, last_v, ref_motion);
      ref_mode   = next_mode(ref_mode, cap_cmd_valid && (cap_cmd == cam_pkg::cmd_stop),
                             cap_cmd_valid && (cap_cmd == cam_pkg::cmd_start),
                             last_vv, last_v.detected);
      check_motion($sformatf("motion cycle %0d", cycle), ref_motion, motion);
      if (mode_tracking !== (ref_mode == MODE_TRACK)) begin
        motion_errs++;
        $display("MISMATCH mode_tracking cycle %0d expected %0b actual %0b",
                 cycle, (ref_mode == MODE_TRACK), mode_tracking);
      end
      // preview scoreboard
      if (prev_valid) begin
        if (pix_q.size() == 0) begin
          other_errs++;
          $display("preview strobe at cycle %0d with no pixel expected", cycle);
        end else begin
          if (pix_due[0] != cycle) begin
            other_errs++;
            $display("preview pixel at cycle %0d, due at cycle %0d", cycle, pix_due[0]);
          end
          check_pixel($sformatf("preview frame %0d", pix_frame[0]), pix_q[0], prev_pix);
          pix_q.delete(0);
          pix_due.delete(0);
          pix_frame.delete(0);
        end
      end else if ((pix_q.size() != 0) && (pix_due[0] <= cycle)) begin
        other_errs++;
        $display("preview pixel of frame %0d did not appear at cycle %0d",
                 pix_frame[0], pix_due[0]);
        pix_q.delete(0);
        pix_due.delete(0);
        pix_frame.delete(0);
      end
      // one verdict per frame, three cycles after raw eof
      if (verdict_valid) begin
        if (verdict_q.size() == 0) begin
          other_errs++;
          $display("verdict strobe at cycle %0d with no frame ended", cycle);
        end else begin
          if (verdict_due[0] != cycle) begin
            other_errs++;
            $display("verdict at cycle %0d, due at cycle %0d", cycle, verdict_due[0]);
          end
          check_verdict($sformatf("verdict frame %0d", verdict_frame[0]), verdict_q[0], verdict);
          verdict_q.delete(0);
          verdict_due.delete(0);
          verdict_frame.delete(0);
        end
      end else if ((verdict_q.size() != 0) && (verdict_due[0] <= cycle)) begin
        other_errs++;
        $display("verdict of frame %0d did not appear at cycle %0d",
                 verdict_frame[0], verdict_due[0]);
        verdict_q.delete(0);
        verdict_due.delete(0);
        verdict_frame.delete(0);
      end
      last_vv = verdict_valid;
      last_v  = verdict;
    end
  end

  initial begin
    lfsr      = 32'hd81;
    rst       = 1'b1;
    raw_valid = 1'b0;
    raw       = '0;
    cmd_valid = 1'b0;
    cmd       = cam_pkg::cmd_none;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    idle(2);

    // idle mode ignores a clear centre target
    send_frame(0, 20, 0, 1'b0);
    idle(6);
    send_cmd(cam_pkg::cmd_start);
    idle(2);
    // two sparse frames, six in total must not add up
    send_frame(3, 0, 0, 1'b1);
    idle(6);
    send_frame(0, 0, 3, 1'b1);
    idle(6);
    // one third dominant, noisy background
    send_frame(0, 0, 20, 1'b0);
    idle(6);
    send_frame(0, 20, 0, 1'b0);
    idle(6);
    send_frame(20, 0, 0, 1'b0);
    idle(6);
    // ties and the MIN_COUNT boundary
    send_frame(4, 4, 4, 1'b1);
    idle(6);
    send_frame(5, 0, 5, 1'b1);
    idle(6);
    send_frame(3, 3, 0, 1'b1);
    idle(6);
    // lost target, back to search
    send_frame(2, 0, 0, 1'b1);
    idle(6);
    // stop lands on the same edge as the verdict
    send_frame(20, 0, 0, 1'b0);
    idle(2);
    send_cmd(cam_pkg::cmd_stop);
    idle(6);
    send_frame(0, 0, 20, 1'b0);
    idle(6);
    send_cmd(cam_pkg::cmd_start);
    send_frame(0, 20, 0, 1'b0);

    // drain the pipeline, timeout covers a stuck DUT
    // first edge captures the eof pixel
    idle(1);
    while ((pix_q.size() != 0) || (verdict_q.size() != 0)) begin
      idle(1);
    end
    // motion follows the last verdict one edge later
    idle(2);
    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tests
hdl/cam_pkg.sv
hdl/pixel_unpack.sv
hdl/orange_detector.sv
hdl/direction_classifier.sv
hdl/drive_fsm.sv
hdl/target_tracker_top.sv
tests/tb_target_tracker.sv

//--- Bender.yml
package:
  name: target_tracker

sources:
  - hdl/cam_pkg.sv
  - hdl/pixel_unpack.sv
  - hdl/orange_detector.sv
  - hdl/direction_classifier.sv
  - hdl/drive_fsm.sv
  - hdl/target_tracker_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_target_tracker.sv
